// ==== Bender.yml ====
package:
  name: traffic_gen

sources:
  # Package first, then the design bottom up
  - hw/traffic_pkg.sv
  - hw/addr_gen.sv
  - hw/read_compare.sv
  - hw/single_rw_stage.sv
  - hw/block_rw_stage.sv
  - hw/driver_fsm.sv
  - hw/traffic_gen_top.sv
  - target: simulation
    files:
      - sim/traffic_checker.sv
      - sim/tb_traffic_gen.sv

// ==== build.f ====
hw/traffic_pkg.sv
hw/addr_gen.sv
hw/read_compare.sv
hw/single_rw_stage.sv
hw/block_rw_stage.sv
hw/driver_fsm.sv
hw/traffic_gen_top.sv
sim/traffic_checker.sv
sim/tb_traffic_gen.sv

// ==== hw/addr_gen.sv ====
// Address generator
module addr_gen (
	input  logic                           clk,
	input  logic                           reset_n,
	input  traffic_pkg::addr_gen_select_t  select,
	input  logic                           advance,
	input  logic                           restart,
	output logic [traffic_pkg::ADDR_W-1:0] addr
);

	logic [traffic_pkg::ADDR_W-1:0] lfsr;
	logic [traffic_pkg::ADDR_W-1:0] seq_addr;
	traffic_pkg::addr_gen_select_t select_q;
	logic start;

	// Galois step, shift right
	function automatic logic [traffic_pkg::ADDR_W-1:0] lfsr_step(
		input logic [traffic_pkg::ADDR_W-1:0] s
	);
		return {1'b0, s[traffic_pkg::ADDR_W-1:1]} ^ (s[0] ? traffic_pkg::LFSR_TAPS : '0);
	endfunction

	// New mode on idle or on any select change
	assign start = restart || (select != select_q);
	// RAND reads the LFSR, SEQ and RAND_SEQ the counter
	assign addr = (select == traffic_pkg::RAND) ? lfsr : seq_addr;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			lfsr <= traffic_pkg::RAND_SEED;
			seq_addr <= '0;
			select_q <= traffic_pkg::SEQ;
		end
		else
		begin
			select_q <= select;
			if (start)
			begin
				if (select == traffic_pkg::RAND_SEQ)
				begin
					// Random base, sequential after it
					seq_addr <= lfsr;
					lfsr <= lfsr_step(lfsr);
				end
				else
					seq_addr <= '0;
			end
			else if (advance)
			begin
				if (select == traffic_pkg::RAND)
					lfsr <= lfsr_step(lfsr);
				else
					seq_addr <= seq_addr + 1'b1;
			end
		end
	end

endmodule

// ==== hw/block_rw_stage.sv ====
// Block write then read stage
module block_rw_stage (
	input  logic                           clk,
	input  logic                           reset_n,
	input  logic                           stage_enable,
	input  logic                           can_write,
	input  logic                           can_read,
	input  logic                           cmp_empty,
	input  logic [traffic_pkg::ADDR_W-1:0] addr,
	output traffic_pkg::mem_cmd_t          cmd,
	output traffic_pkg::addr_gen_select_t  addr_gen_select,
	output logic                           stage_complete
);

	typedef enum logic [2:0] {
		IDLE,
		START,
		WRITE,
		READ,
		DRAIN
	} state_t;

	state_t state;
	traffic_pkg::addr_gen_select_t mode;
	logic [traffic_pkg::BLK_W-1:0] wr_idx;
	logic [traffic_pkg::BLK_W-1:0] rd_idx;
	logic [traffic_pkg::CNT_W-1:0] acc_cnt;
	logic [traffic_pkg::ADDR_W-1:0] base;
	logic [traffic_pkg::ADDR_W-1:0] wr_addr;
	logic last_acc;

	assign addr_gen_select = mode;
	assign last_acc = (acc_cnt == traffic_pkg::mode_count(mode) - 1'b1);
	// First write takes the generator, the rest follow it
	assign wr_addr = (wr_idx == '0) ? addr : base + traffic_pkg::ADDR_W'(wr_idx);

	always_comb
	begin
		cmd.write = (state == WRITE) && can_write;
		cmd.read = (state == READ) && can_read;
		cmd.addr = (state == READ) ? base + traffic_pkg::ADDR_W'(rd_idx) : wr_addr;
		cmd.wdata = traffic_pkg::data_pattern(wr_addr);
	end

	// Block start address
	always_ff @(posedge clk)
	begin
		if ((state == WRITE) && can_write && (wr_idx == '0))
			base <= addr;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= IDLE;
			mode <= traffic_pkg::SEQ;
			wr_idx <= '0;
			rd_idx <= '0;
			acc_cnt <= '0;
			stage_complete <= 1'b0;
		end
		else
		begin
			stage_complete <= 1'b0;
			case (state)
				IDLE:
					if (stage_enable && !stage_complete)
						state <= START;
				START:
					state <= WRITE;
				WRITE:
					// Write phase of the block
					if (can_write)
					begin
						wr_idx <= wr_idx + 1'b1;
						if (wr_idx == traffic_pkg::BLOCK_LAST)
							state <= READ;
					end
				READ:
					// Read the block back in write order
					if (can_read)
					begin
						rd_idx <= rd_idx + 1'b1;
						acc_cnt <= last_acc ? '0 : acc_cnt + 1'b1;
						if (last_acc)
							state <= DRAIN;
						else if (rd_idx == traffic_pkg::BLOCK_LAST)
							state <= WRITE;
					end
				default:
					if (cmp_empty)
					begin
						if (mode == traffic_pkg::RAND_SEQ)
						begin
							mode <= traffic_pkg::SEQ;
							stage_complete <= 1'b1;
							state <= IDLE;
						end
						else
						begin
							mode <= traffic_pkg::next_mode(mode);
							state <= START;
						end
					end
			endcase
		end
	end

	// Read phase starts on a whole written block, read index at its start
	a_block_written: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(state == READ) |-> (wr_idx == '0) && (rd_idx == '0))
		else $error("block read phase out of step with the written block");

endmodule

// ==== hw/driver_fsm.sv ====
// Test stage sequencer
module driver_fsm (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          can_write,
	input  logic                          can_read,
	input  logic                          cmp_full,
	input  traffic_pkg::mem_cmd_t         single_cmd,
	input  traffic_pkg::addr_gen_select_t single_sel,
	input  logic                          single_done,
	input  traffic_pkg::mem_cmd_t         block_cmd,
	input  traffic_pkg::addr_gen_select_t block_sel,
	input  logic                          block_done,
	output traffic_pkg::mem_cmd_t         mem_cmd,
	output traffic_pkg::addr_gen_select_t addr_gen_select,
	output logic                          single_enable,
	output logic                          block_enable,
	output logic                          test_complete,
	output logic                          timeout,
	output logic [31:0]                   loop_counter
);

	traffic_pkg::test_stage_t stage;
	// Extra bit flags the timeout
	logic [traffic_pkg::TIMEOUT_W:0] timeout_cnt;
	logic end_state;

	// Stage enables and status decodes
	assign single_enable = (stage == traffic_pkg::SINGLE_RW);
	assign block_enable = (stage == traffic_pkg::BLOCK_RW);
	assign end_state = (stage == traffic_pkg::TEST_COMPLETE) || (stage == traffic_pkg::TIMEOUT);
	assign test_complete = end_state;
	assign timeout = (stage == traffic_pkg::TIMEOUT);

	//////////////////////////////////////////////////
	// Command mux
	//////////////////////////////////////////////////
	always_comb
	begin
		case (stage)
			traffic_pkg::SINGLE_RW:
			begin
				mem_cmd = single_cmd;
				addr_gen_select = single_sel;
			end
			traffic_pkg::BLOCK_RW:
			begin
				mem_cmd = block_cmd;
				addr_gen_select = block_sel;
			end
			default:
			begin
				// Idle, no commands
				mem_cmd = '0;
				addr_gen_select = traffic_pkg::SEQ;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Stage sequence
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			stage <= traffic_pkg::INIT;
			timeout_cnt <= '0;
			loop_counter <= '0;
		end
		else
		begin
			timeout_cnt <= timeout_cnt + 1'b1;
			if (end_state)
				// Final states hold until reset
				timeout_cnt <= '0;
			else if (timeout_cnt[traffic_pkg::TIMEOUT_W] || cmp_full)
				// Loop too slow, or compare FIFO overflowing
				stage <= traffic_pkg::TIMEOUT;
			else
			begin
				case (stage)
					traffic_pkg::INIT:
					begin
						// New loop, restart the timeout window
						timeout_cnt <= '0;
						loop_counter <= loop_counter + 1'b1;
						stage <= traffic_pkg::SINGLE_RW;
					end
					traffic_pkg::SINGLE_RW:
						if (single_done)
							stage <= traffic_pkg::BLOCK_RW;
					traffic_pkg::BLOCK_RW:
						if (block_done)
							stage <= traffic_pkg::DONE;
					default:
						// DONE, loop again or finish
						if ((traffic_pkg::NUM_DRIVER_LOOP == 0) ||
							(loop_counter < 32'(traffic_pkg::NUM_DRIVER_LOOP)))
							stage <= traffic_pkg::INIT;
						else
							stage <= traffic_pkg::TEST_COMPLETE;
				endcase
			end
		end
	end

	// Stages must respect the memory back-pressure
	a_write_ready: assert property (@(posedge clk) disable iff (!reset_n)
		mem_cmd.write |-> can_write)
		else $error("write issued while can_write low");
	a_read_ready: assert property (@(posedge clk) disable iff (!reset_n)
		mem_cmd.read |-> can_read)
		else $error("read issued while can_read low");
	// One stage issuing at a time
	a_one_stage: assert property (@(posedge clk) disable iff (!reset_n)
		!((single_cmd.write || single_cmd.read) && (block_cmd.write || block_cmd.read)))
		else $error("both stages issuing commands");

endmodule

// ==== hw/read_compare.sv ====
// Read data compare
module read_compare (
	input  logic                           clk,
	input  logic                           reset_n,
	input  logic                           issue_read,
	input  logic [traffic_pkg::ADDR_W-1:0] issue_addr,
	input  traffic_pkg::rd_rsp_t           rd_rsp,
	output logic                           cmp_empty,
	output logic                           cmp_full,
	output logic [15:0]                    error_count,
	output logic                           pass
);

	localparam int PW = traffic_pkg::CMP_PTR_W;

	// Expected words in read issue order
	logic [traffic_pkg::DATA_W-1:0] fifo_mem [traffic_pkg::CMP_FIFO_DEPTH];
	// Extra pointer bit tells full from empty
	logic [PW:0] wr_ptr;
	logic [PW:0] rd_ptr;
	logic pop;
	// Compare stage, one cycle after the return
	logic rsp_valid_q;
	logic expected_ok;
	logic [traffic_pkg::DATA_W-1:0] expected;
	logic [traffic_pkg::DATA_W-1:0] rdata_q;

	assign cmp_empty = (wr_ptr == rd_ptr);
	assign cmp_full = (wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);
	assign pop = rd_rsp.valid && !cmp_empty;

	// FIFO storage and compare operands
	always_ff @(posedge clk)
	begin
		if (issue_read)
			fifo_mem[wr_ptr[PW-1:0]] <= traffic_pkg::data_pattern(issue_addr);
		if (rd_rsp.valid)
		begin
			expected <= fifo_mem[rd_ptr[PW-1:0]];
			rdata_q <= rd_rsp.rdata;
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			rsp_valid_q <= 1'b0;
			expected_ok <= 1'b0;
			error_count <= '0;
			pass <= 1'b1;
		end
		else
		begin
			if (issue_read)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			rsp_valid_q <= rd_rsp.valid;
			// A return with nothing expected is an error too
			expected_ok <= !cmp_empty;
			if (rsp_valid_q && (!expected_ok || (rdata_q != expected)))
			begin
				error_count <= error_count + 1'b1;
				pass <= 1'b0;
			end
		end
	end

	// FIFO depth must cover all outstanding reads
	a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
		issue_read |-> !cmp_full)
		else $error("compare FIFO push while full");

endmodule

// ==== hw/single_rw_stage.sv ====
// Single write then read stage
module single_rw_stage (
	input  logic                           clk,
	input  logic                           reset_n,
	input  logic                           stage_enable,
	input  logic                           can_write,
	input  logic                           can_read,
	input  logic                           cmp_empty,
	input  logic [traffic_pkg::ADDR_W-1:0] addr,
	output traffic_pkg::mem_cmd_t          cmd,
	output traffic_pkg::addr_gen_select_t  addr_gen_select,
	output logic                           stage_complete
);

	// START gives the generator a cycle after a mode change
	typedef enum logic [2:0] {
		IDLE,
		START,
		WRITE,
		READ,
		DRAIN
	} state_t;

	state_t state;
	traffic_pkg::addr_gen_select_t mode;
	logic [traffic_pkg::CNT_W-1:0] pair_cnt;
	logic [traffic_pkg::ADDR_W-1:0] cur_addr;
	logic last_pair;

	assign addr_gen_select = mode;
	assign last_pair = (pair_cnt == traffic_pkg::mode_count(mode) - 1'b1);

	// Write at the generated address, read back the held one
	always_comb
	begin
		cmd.write = (state == WRITE) && can_write;
		cmd.read = (state == READ) && can_read;
		cmd.addr = (state == READ) ? cur_addr : addr;
		cmd.wdata = traffic_pkg::data_pattern(addr);
	end

	// Address of the pending read
	always_ff @(posedge clk)
	begin
		if ((state == WRITE) && can_write)
			cur_addr <= addr;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= IDLE;
			mode <= traffic_pkg::SEQ;
			pair_cnt <= '0;
			stage_complete <= 1'b0;
		end
		else
		begin
			stage_complete <= 1'b0;
			case (state)
				IDLE:
					// Enable still high during the done pulse
					if (stage_enable && !stage_complete)
						state <= START;
				START:
					state <= WRITE;
				WRITE:
					if (can_write)
						state <= READ;
				READ:
					if (can_read)
					begin
						pair_cnt <= last_pair ? '0 : pair_cnt + 1'b1;
						state <= last_pair ? DRAIN : WRITE;
					end
				default:
					// Blocking mode switch, all reads returned
					if (cmp_empty)
					begin
						if (mode == traffic_pkg::RAND_SEQ)
						begin
							mode <= traffic_pkg::SEQ;
							stage_complete <= 1'b1;
							state <= IDLE;
						end
						else
						begin
							mode <= traffic_pkg::next_mode(mode);
							state <= START;
						end
					end
			endcase
		end
	end

endmodule

// ==== hw/traffic_gen_top.sv ====
// Memory traffic generator top
module traffic_gen_top (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  can_write,
	input  logic                  can_read,
	input  traffic_pkg::rd_rsp_t  rd_rsp,
	output traffic_pkg::mem_cmd_t mem_cmd,
	output logic                  test_complete,
	output logic                  timeout,
	output logic                  pass,
	output logic [31:0]           loop_counter,
	output logic [15:0]           error_count
);

	traffic_pkg::mem_cmd_t single_cmd;
	traffic_pkg::mem_cmd_t block_cmd;
	traffic_pkg::addr_gen_select_t single_sel;
	traffic_pkg::addr_gen_select_t block_sel;
	traffic_pkg::addr_gen_select_t gen_sel;
	logic single_done;
	logic block_done;
	logic single_enable;
	logic block_enable;
	logic cmp_empty;
	logic cmp_full;
	logic [traffic_pkg::ADDR_W-1:0] gen_addr;

	//////////////////////////////////////////////////
	// Sequencer and stages
	//////////////////////////////////////////////////
	driver_fsm u_driver (
		.clk             (clk),
		.reset_n         (reset_n),
		.can_write       (can_write),
		.can_read        (can_read),
		.cmp_full        (cmp_full),
		.single_cmd      (single_cmd),
		.single_sel      (single_sel),
		.single_done     (single_done),
		.block_cmd       (block_cmd),
		.block_sel       (block_sel),
		.block_done      (block_done),
		.mem_cmd         (mem_cmd),
		.addr_gen_select (gen_sel),
		.single_enable   (single_enable),
		.block_enable    (block_enable),
		.test_complete   (test_complete),
		.timeout         (timeout),
		.loop_counter    (loop_counter)
	);

	single_rw_stage u_single (
		.clk             (clk),
		.reset_n         (reset_n),
		.stage_enable    (single_enable),
		.can_write       (can_write),
		.can_read        (can_read),
		.cmp_empty       (cmp_empty),
		.addr            (gen_addr),
		.cmd             (single_cmd),
		.addr_gen_select (single_sel),
		.stage_complete  (single_done)
	);

	block_rw_stage u_block (
		.clk             (clk),
		.reset_n         (reset_n),
		.stage_enable    (block_enable),
		.can_write       (can_write),
		.can_read        (can_read),
		.cmp_empty       (cmp_empty),
		.addr            (gen_addr),
		.cmd             (block_cmd),
		.addr_gen_select (block_sel),
		.stage_complete  (block_done)
	);

	// Steps on each issued write, restarts while no stage runs
	addr_gen u_addr_gen (
		.clk     (clk),
		.reset_n (reset_n),
		.select  (gen_sel),
		.advance (mem_cmd.write),
		.restart (!(single_enable || block_enable)),
		.addr    (gen_addr)
	);

	read_compare u_compare (
		.clk         (clk),
		.reset_n     (reset_n),
		.issue_read  (mem_cmd.read),
		.issue_addr  (mem_cmd.addr),
		.rd_rsp      (rd_rsp),
		.cmp_empty   (cmp_empty),
		.cmp_full    (cmp_full),
		.error_count (error_count),
		.pass        (pass)
	);

endmodule

// ==== hw/traffic_pkg.sv ====
// Traffic generator shared definitions
package traffic_pkg;

	//////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////
	localparam int ADDR_W = 10;
	localparam int DATA_W = 16;
	localparam int SEQ_ADDR_COUNT = 4;
	localparam int RAND_ADDR_COUNT = 4;
	localparam int RAND_SEQ_ADDR_COUNT = 4;
	localparam int BLOCK_SIZE = 4;
	// Zero means run forever
	localparam int NUM_DRIVER_LOOP = 2;
	localparam int TIMEOUT_W = 12;
	localparam int CMP_FIFO_DEPTH = 8;
	localparam int CMP_PTR_W = $clog2(CMP_FIFO_DEPTH);
	// Per-mode access counter and block index widths
	localparam int CNT_W = 8;
	localparam int BLK_W = $clog2(BLOCK_SIZE);
	localparam logic [BLK_W-1:0] BLOCK_LAST = BLK_W'(BLOCK_SIZE - 1);
	// LFSR seed and taps, x^10 + x^7 + 1
	localparam logic [ADDR_W-1:0] RAND_SEED = 10'h1A7;
	localparam logic [ADDR_W-1:0] LFSR_TAPS = 10'h240;
	localparam logic [7:0] PATTERN_KEY = 8'hA5;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {
		SEQ,
		RAND,
		RAND_SEQ
	} addr_gen_select_t;

	typedef enum logic [2:0] {
		INIT,
		SINGLE_RW,
		BLOCK_RW,
		DONE,
		TEST_COMPLETE,
		TIMEOUT
	} test_stage_t;

	// Command to the memory port
	typedef struct packed {
		logic write;
		logic read;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_cmd_t;

	// Read return from the memory port
	typedef struct packed {
		logic valid;
		logic [DATA_W-1:0] rdata;
	} rd_rsp_t;

	// Data word for an address, upper byte scrambled
	function automatic logic [DATA_W-1:0] data_pattern(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] word;
		word = DATA_W'(addr);
		word[DATA_W-1 -: 8] = word[DATA_W-1 -: 8] ^ PATTERN_KEY;
		return word;
	endfunction

	// Number of accesses in each address mode
	function automatic logic [CNT_W-1:0] mode_count(input addr_gen_select_t sel);
		case (sel)
			SEQ: return CNT_W'(SEQ_ADDR_COUNT);
			RAND: return CNT_W'(RAND_ADDR_COUNT);
			default: return CNT_W'(RAND_SEQ_ADDR_COUNT);
		endcase
	endfunction

	// Mode order inside a stage
	function automatic addr_gen_select_t next_mode(input addr_gen_select_t sel);
		case (sel)
			SEQ: return RAND;
			default: return RAND_SEQ;
		endcase
	endfunction

endpackage

// ==== sim/tb_traffic_gen.sv ====
// Traffic generator testbench
module tb_traffic_gen;

	localparam int NUM_ROWS = 4;
	localparam int ROW_CYCLES = 5000;
	localparam int MEM_WORDS = 1 << traffic_pkg::ADDR_W;

	// One scenario, corrupt_idx below zero means no corruption
	typedef struct packed {
		logic backpressure;
		logic signed [7:0] corrupt_idx;
		logic stall_write;
		logic exp_pass;
		logic exp_timeout;
	} scenario_t;

	logic clk;
	logic reset_n;
	logic can_write;
	logic can_read;
	traffic_pkg::rd_rsp_t rd_rsp;
	traffic_pkg::mem_cmd_t mem_cmd;
	logic test_complete;
	logic timeout;
	logic pass;
	logic [31:0] loop_counter;
	logic [15:0] error_count;
	scenario_t scenarios [NUM_ROWS];
	scenario_t cur;
	logic row_done;
	logic [15:0] exp_errors;
	logic [31:0] exp_loops;
	int error_total;
	logic [15:0] rng;
	// Memory model and in-order return queue
	logic [traffic_pkg::DATA_W-1:0] mem [MEM_WORDS];
	int cycle;
	int read_idx;
	int last_due;
	int due_q [$];
	logic [traffic_pkg::DATA_W-1:0] data_q [$];

	traffic_gen_top uut (
		.clk           (clk),
		.reset_n       (reset_n),
		.can_write     (can_write),
		.can_read      (can_read),
		.rd_rsp        (rd_rsp),
		.mem_cmd       (mem_cmd),
		.test_complete (test_complete),
		.timeout       (timeout),
		.pass          (pass),
		.loop_counter  (loop_counter),
		.error_count   (error_count)
	);

	traffic_checker u_checker (
		.clk           (clk),
		.reset_n       (reset_n),
		.can_write     (can_write),
		.can_read      (can_read),
		.mem_cmd       (mem_cmd),
		.test_complete (test_complete),
		.timeout       (timeout),
		.pass          (pass),
		.loop_counter  (loop_counter),
		.error_count   (error_count),
		.no_cmd        (cur.stall_write),
		.row_done      (row_done),
		.exp_pass      (cur.exp_pass),
		.exp_timeout   (cur.exp_timeout),
		.exp_errors    (exp_errors),
		.exp_loops     (exp_loops),
		.error_total   (error_total)
	);

	// x^16 + x^14 + x^13 + x^11 + 1, shift right
	function automatic logic [15:0] galois_step(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// One step per bit taken
	function automatic logic random_bit();
		rng = galois_step(rng);
		return rng[0];
	endfunction

	function automatic scenario_t make_row(input logic bp, input int corrupt, input logic stall,
		input logic p, input logic t);
		scenario_t row;
		row.backpressure = bp;
		row.corrupt_idx = 8'(corrupt);
		row.stall_write = stall;
		row.exp_pass = p;
		row.exp_timeout = t;
		return row;
	endfunction

	task automatic apply_reset();
		reset_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 reset_n = 1'b1;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////
	always @(posedge clk)
	begin : mem_model
		logic [1:0] lat;
		int due;
		cycle = cycle + 1;
		if (!reset_n)
		begin
			due_q.delete();
			data_q.delete();
			read_idx = 0;
			last_due = 0;
		end
		else
		begin
			if (mem_cmd.write)
				mem[mem_cmd.addr] = mem_cmd.wdata;
			if (mem_cmd.read)
			begin
				// Latency 2 to 5, returns kept in order
				lat[0] = random_bit();
				lat[1] = random_bit();
				due = cycle + 2 + int'(lat);
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				due_q.push_back(due);
				data_q.push_back(mem[mem_cmd.addr]);
			end
		end
		#1;
		rd_rsp.valid = 1'b0;
		rd_rsp.rdata = '0;
		if (reset_n && (due_q.size() > 0) && (due_q[0] <= cycle))
		begin
			void'(due_q.pop_front());
			rd_rsp.valid = 1'b1;
			rd_rsp.rdata = data_q.pop_front();
			// Single bit flip on the chosen return
			if (read_idx == int'(cur.corrupt_idx))
				rd_rsp.rdata[3] = ~rd_rsp.rdata[3];
			read_idx = read_idx + 1;
		end
		// Readiness, one LFSR bit each under back-pressure
		if (cur.stall_write)
			can_write = 1'b0;
		else if (cur.backpressure)
			can_write = random_bit();
		else
			can_write = 1'b1;
		can_read = cur.backpressure ? random_bit() : 1'b1;
	end

	//////////////////////////////////////////////////
	// Scenario rows
	//////////////////////////////////////////////////
	initial
	begin
		reset_n = 1'b0;
		can_write = 1'b0;
		can_read = 1'b0;
		rd_rsp = '0;
		row_done = 1'b0;
		rng = 16'd52;
		cycle = 0;
		read_idx = 0;
		last_due = 0;
		// backpressure, corrupt read, write stall, pass, timeout
		scenarios[0] = make_row(1'b0, -1, 1'b0, 1'b1, 1'b0);
		scenarios[1] = make_row(1'b1, -1, 1'b0, 1'b1, 1'b0);
		scenarios[2] = make_row(1'b0, 5, 1'b0, 1'b0, 1'b0);
		scenarios[3] = make_row(1'b0, -1, 1'b1, 1'b1, 1'b1);
		cur = scenarios[0];
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = ~16'(i);
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			cur = scenarios[r];
			exp_errors = (cur.corrupt_idx >= 0) ? 16'd1 : 16'd0;
			exp_loops = cur.exp_timeout ? 32'd1 : 32'(traffic_pkg::NUM_DRIVER_LOOP);
			apply_reset();
			while (!test_complete)
				@(posedge clk);
			// Let the status settle, then compare
			repeat (3) @(posedge clk);
			#1 row_done = 1'b1;
			@(posedge clk);
			#1 row_done = 1'b0;
		end
		$display("Run summary: %0d rows, %0d check errors", NUM_ROWS, error_total);
		if (error_total == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog over all rows
	initial
	begin
		repeat (NUM_ROWS * ROW_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, test_complete not reached",
			NUM_ROWS * ROW_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sim/traffic_checker.sv ====
// Traffic generator checker
module traffic_checker (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  can_write,
	input  logic                  can_read,
	input  traffic_pkg::mem_cmd_t mem_cmd,
	input  logic                  test_complete,
	input  logic                  timeout,
	input  logic                  pass,
	input  logic [31:0]           loop_counter,
	input  logic [15:0]           error_count,
	input  logic                  no_cmd,
	input  logic                  row_done,
	input  logic                  exp_pass,
	input  logic                  exp_timeout,
	input  logic [15:0]           exp_errors,
	input  logic [31:0]           exp_loops,
	output int                    error_total
);

	localparam int MEM_WORDS = 1 << traffic_pkg::ADDR_W;
	localparam int BS = traffic_pkg::BLOCK_SIZE;

	// Addresses written in the current loop
	logic written [MEM_WORDS];
	int loop_wr;
	int loop_rd;
	logic [31:0] prev_loop;
	logic end_checked;

	initial error_total = 0;

	task automatic report(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		error_total = error_total + 1;
	endtask

	// Low data byte is the address, high byte scrambled with A5
	function automatic logic [15:0] expected_word(input logic [9:0] a);
		logic [15:0] w;
		w = {6'b000000, a};
		w[15:8] = w[15:8] ^ 8'hA5;
		return w;
	endfunction

	// Block stage writes whole blocks
	function automatic int block_writes(input int count);
		return ((count + BS - 1) / BS) * BS;
	endfunction

	task automatic clear_loop();
		for (int i = 0; i < MEM_WORDS; i++)
			written[i] = 1'b0;
		loop_wr = 0;
		loop_rd = 0;
	endtask

	// Single pairs plus block totals, per loop
	task automatic check_loop_counts(input logic [31:0] loop_no);
		int exp_wr;
		int exp_rd;
		exp_rd = 2 * (traffic_pkg::SEQ_ADDR_COUNT + traffic_pkg::RAND_ADDR_COUNT +
			traffic_pkg::RAND_SEQ_ADDR_COUNT);
		exp_wr = exp_rd / 2 + block_writes(traffic_pkg::SEQ_ADDR_COUNT) +
			block_writes(traffic_pkg::RAND_ADDR_COUNT) +
			block_writes(traffic_pkg::RAND_SEQ_ADDR_COUNT);
		if (loop_wr != exp_wr)
			report($sformatf("loop %0d: %0d writes, expected %0d", loop_no, loop_wr, exp_wr));
		if (loop_rd != exp_rd)
			report($sformatf("loop %0d: %0d reads, expected %0d", loop_no, loop_rd, exp_rd));
	endtask

	//////////////////////////////////////////////////
	// Per-cycle command checks
	//////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (!reset_n)
		begin
			clear_loop();
			prev_loop = '0;
			end_checked = 1'b0;
		end
		else
		begin
			// Loop boundary
			if (loop_counter != prev_loop)
			begin
				if (prev_loop != 0)
					check_loop_counts(prev_loop);
				clear_loop();
				prev_loop = loop_counter;
			end
			// Last loop of a finished run
			if (test_complete && !timeout && !end_checked)
			begin
				check_loop_counts(loop_counter);
				end_checked = 1'b1;
			end
			if (no_cmd && (mem_cmd.write || mem_cmd.read))
				report("command issued while memory refuses commands");
			if (mem_cmd.write && !can_write)
				report("write while can_write low");
			if (mem_cmd.read && !can_read)
				report("read while can_read low");
			if (mem_cmd.write)
			begin
				if (mem_cmd.wdata !== expected_word(mem_cmd.addr))
					report($sformatf("write addr %h data %h, expected %h", mem_cmd.addr,
						mem_cmd.wdata, expected_word(mem_cmd.addr)));
				written[mem_cmd.addr] = 1'b1;
				loop_wr = loop_wr + 1;
			end
			if (mem_cmd.read)
			begin
				if (!written[mem_cmd.addr])
					report($sformatf("read of addr %h not written in this loop", mem_cmd.addr));
				loop_rd = loop_rd + 1;
			end
		end
	end

	//////////////////////////////////////////////////
	// End of row status
	//////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (row_done)
		begin
			if (test_complete !== 1'b1)
				report("test_complete not held at end of row");
			if (timeout !== exp_timeout)
				report($sformatf("timeout %b, expected %b", timeout, exp_timeout));
			if (pass !== exp_pass)
				report($sformatf("pass %b, expected %b", pass, exp_pass));
			if (error_count !== exp_errors)
				report($sformatf("error_count %0d, expected %0d", error_count, exp_errors));
			if (loop_counter !== exp_loops)
				report($sformatf("loop_counter %0d, expected %0d", loop_counter, exp_loops));
		end
	end

endmodule
